// ==== Bender.yml ====
package:
  name: f8_core

export_include_dirs:
  - hw

sources:
  - files:
      - hw/f8_pkg.sv
      - hw/f8_state_if.sv
      - hw/f8_registers.sv
      - hw/f8_fetch.sv
      - hw/f8_execute.sv
      - hw/f8_bank_split.sv
      - hw/f8_core.sv
  - target: test
    files:
      - test/f8_core_sva.sv
      - test/f8_core_tb.sv

// ==== hw/f8_bank_split.sv ====
`timescale 1ns/1ps
`include "f8_config.svh"

module f8_bank_split
(
	input logic clk,
	input logic reset,
	input logic [`F8_ADDR_W-1:0] read_addr,
	output logic [15:0] read_word,
	input logic [`F8_ADDR_W-1:0] write_addr,
	input logic [15:0] write_data,
	input logic [1:0] write_en,
	output logic [`F8_BANK_ADDR_W-1:0] mem_read_addr_even,
	output logic [`F8_BANK_ADDR_W-1:0] mem_read_addr_odd,
	input logic [7:0] mem_read_data_even,
	input logic [7:0] mem_read_data_odd,
	output logic [`F8_BANK_ADDR_W-1:0] mem_write_addr_even,
	output logic [`F8_BANK_ADDR_W-1:0] mem_write_addr_odd,
	output logic [7:0] mem_write_data_even,
	output logic [7:0] mem_write_data_odd,
	output logic mem_write_en_even,
	output logic mem_write_en_odd
);
	localparam logic [`F8_BANK_ADDR_W-1:0] BANK_ZERO = '0;

	logic read_odd;

	// an odd access starts in the odd bank and wraps into the next even word
	assign mem_read_addr_odd = read_addr[`F8_ADDR_W-1:1];
	assign mem_read_addr_even = read_addr[`F8_ADDR_W-1:1] + (BANK_ZERO | read_addr[0]);

	always_ff @(posedge clk)
	begin
		if (reset)
			read_odd <= 1'b0;
		else
			read_odd <= read_addr[0];
	end

	assign read_word = read_odd ? {mem_read_data_even, mem_read_data_odd} :
		{mem_read_data_odd, mem_read_data_even};

	assign mem_write_addr_odd = write_addr[`F8_ADDR_W-1:1];
	assign mem_write_addr_even = write_addr[`F8_ADDR_W-1:1] + (BANK_ZERO | write_addr[0]);
	assign mem_write_data_even = write_addr[0] ? write_data[15:8] : write_data[7:0];
	assign mem_write_data_odd = write_addr[0] ? write_data[7:0] : write_data[15:8];
	assign mem_write_en_even = write_addr[0] ? write_en[1] : write_en[0];
	assign mem_write_en_odd = write_addr[0] ? write_en[0] : write_en[1];
endmodule

// ==== hw/f8_config.svh ====
`ifndef F8_CONFIG_SVH
`define F8_CONFIG_SVH

// byte address into the unified memory
`define F8_ADDR_W 16

// word address into either byte bank
`define F8_BANK_ADDR_W 15

// first instruction fetched after reset
`define F8_RESET_VECTOR 16'h4000

`endif

// ==== hw/f8_core.sv ====
`timescale 1ns/1ps
`include "f8_config.svh"

module f8_core
(
	input logic clk,
	input logic reset,
	output logic [`F8_BANK_ADDR_W-1:0] mem_read_addr_even,
	output logic [`F8_BANK_ADDR_W-1:0] mem_read_addr_odd,
	input logic [7:0] mem_read_data_even,
	input logic [7:0] mem_read_data_odd,
	output logic [`F8_BANK_ADDR_W-1:0] mem_write_addr_even,
	output logic [`F8_BANK_ADDR_W-1:0] mem_write_addr_odd,
	output logic [7:0] mem_write_data_even,
	output logic [7:0] mem_write_data_odd,
	output logic mem_write_en_even,
	output logic mem_write_en_odd,
	output logic trap
);
	import f8_pkg::*;

	logic [`F8_ADDR_W-1:0] read_addr;
	logic [15:0] read_word;
	logic [`F8_ADDR_W-1:0] write_addr;
	logic [15:0] write_data;
	logic [1:0] write_en;
	opcode_t opcode;
	inst_tail_u tail;
	logic execute;

	f8_state_if st();

	f8_registers f8_registers_i(.clk(clk), .reset(reset), .st(st.regs));

	f8_fetch f8_fetch_i(.clk(clk), .reset(reset), .st(st.fetch), .read_word(read_word),
		.read_addr(read_addr), .opcode(opcode), .tail(tail), .execute(execute));

	f8_execute f8_execute_i(.st(st.exec), .opcode(opcode), .tail(tail), .read_word(read_word),
		.execute(execute), .write_addr(write_addr), .write_data(write_data),
		.write_en(write_en), .trap(trap));

	f8_bank_split f8_bank_split_i(.clk(clk), .reset(reset), .read_addr(read_addr),
		.read_word(read_word), .write_addr(write_addr), .write_data(write_data),
		.write_en(write_en), .mem_read_addr_even(mem_read_addr_even),
		.mem_read_addr_odd(mem_read_addr_odd), .mem_read_data_even(mem_read_data_even),
		.mem_read_data_odd(mem_read_data_odd), .mem_write_addr_even(mem_write_addr_even),
		.mem_write_addr_odd(mem_write_addr_odd), .mem_write_data_even(mem_write_data_even),
		.mem_write_data_odd(mem_write_data_odd), .mem_write_en_even(mem_write_en_even),
		.mem_write_en_odd(mem_write_en_odd));
endmodule

// ==== hw/f8_execute.sv ====
`timescale 1ns/1ps

module f8_execute
(
	f8_state_if.exec st,
	input f8_pkg::opcode_t opcode,
	input f8_pkg::inst_tail_u tail,
	input logic [15:0] read_word,
	input logic execute,
	output logic [15:0] write_addr,
	output logic [15:0] write_data,
	output logic [1:0] write_en,
	output logic trap
);
	import f8_pkg::*;

	localparam logic REG_X = 1'b0;
	localparam logic REG_Y = 1'b1;

	logic [7:0] xl;
	logic [7:0] operand;
	logic [7:0] add_b;
	logic add_cin;
	logic [8:0] sum;
	logic [7:0] logic_result;

	assign xl = st.x[7:0];
	assign operand = opcode_loads_operand(opcode) ? read_word[7:0] : tail.b.d8;
	assign trap = execute && opcode == TRAP;

	// one adder for add, sub, inc and dec; carry out is the no-borrow flag on subtraction
	always_comb
	begin
		add_b = operand;
		add_cin = 1'b0;
		case (opcode)
			SUB_XL_IMMD, SUB_XL_DIR:
			begin
				add_b = ~operand;
				add_cin = 1'b1;
			end
			INC_XL:
			begin
				add_b = 8'h00;
				add_cin = 1'b1;
			end
			DEC_XL:
			begin
				add_b = 8'hfe;
				add_cin = 1'b1;
			end
			default:
			begin
			end
		endcase
		sum = {1'b0, xl} + {1'b0, add_b} + {8'h00, add_cin};
	end

	always_comb
	begin
		case (opcode)
			AND_XL_IMMD:
				logic_result = xl & operand;
			OR_XL_IMMD:
				logic_result = xl | operand;
			XOR_XL_IMMD:
				logic_result = xl ^ operand;
			LD_XL_YL:
				logic_result = st.y[7:0];
			default:
				logic_result = operand;
		endcase
	end

	always_comb
	begin
		logic taken;
		st.next_pc = st.pc;
		st.next_f = st.f;
		st.reg_wr_sel = REG_X;
		st.reg_wr_data = '0;
		st.reg_wr_en = 2'b00;
		write_addr = tail.word;
		write_data = '0;
		write_en = 2'b00;
		case (opcode)
			JR_D:
				taken = 1'b1;
			JRZ_D:
				taken = st.f[FLAG_Z];
			JRNZ_D:
				taken = !st.f[FLAG_Z];
			JRC_D:
				taken = st.f[FLAG_C];
			JRNC_D:
				taken = !st.f[FLAG_C];
			default:
				taken = 1'b0;
		endcase
		if (execute)
		begin
			st.next_pc = st.pc + opcode_size(opcode);
			case (opcode)
				ADD_XL_IMMD, SUB_XL_IMMD, ADD_XL_DIR, SUB_XL_DIR, INC_XL, DEC_XL:
				begin
					st.reg_wr_data = {sum[7:0], sum[7:0]};
					st.reg_wr_en = 2'b01;
					st.next_f[FLAG_C] = sum[8];
					st.next_f[FLAG_N] = sum[7];
					st.next_f[FLAG_Z] = sum[7:0] == 8'h00;
				end
				AND_XL_IMMD, OR_XL_IMMD, XOR_XL_IMMD, LD_XL_IMMD, LD_XL_DIR, LD_XL_YL:
				begin
					st.reg_wr_data = {logic_result, logic_result};
					st.reg_wr_en = 2'b01;
					st.next_f[FLAG_N] = logic_result[7];
					st.next_f[FLAG_Z] = logic_result == 8'h00;
				end
				CLR_XL:
					st.reg_wr_en = 2'b01;
				LDW_Y_IMMD:
				begin
					// word load sets N and Z from the full 16 bits
					st.reg_wr_sel = REG_Y;
					st.reg_wr_data = tail.word;
					st.reg_wr_en = 2'b11;
					st.next_f[FLAG_N] = tail.word[15];
					st.next_f[FLAG_Z] = tail.word == 16'h0000;
				end
				LD_DIR_XL:
				begin
					write_data = {8'h00, xl};
					write_en = 2'b01;
				end
				LDW_DIR_Y:
				begin
					write_data = st.y;
					write_en = 2'b11;
				end
				JP_IMMD:
					st.next_pc = tail.word;
				JR_D, JRZ_D, JRNZ_D, JRC_D, JRNC_D:
				begin
					// displacement counts from the address of the jr opcode
					if (taken)
						st.next_pc = st.pc + {{8{tail.b.d8[7]}}, tail.b.d8};
				end
				TRAP:
					st.next_pc = st.pc;
				default:
				begin
				end
			endcase
		end
	end
endmodule

// ==== hw/f8_fetch.sv ====
`timescale 1ns/1ps

module f8_fetch
(
	input logic clk,
	input logic reset,
	f8_state_if.fetch st,
	input logic [15:0] read_word,
	output logic [15:0] read_addr,
	output f8_pkg::opcode_t opcode,
	output f8_pkg::inst_tail_u tail,
	output logic execute
);
	import f8_pkg::*;

	typedef enum logic [1:0]
	{
		PH_NEW,
		PH_UPPER,
		PH_OPERAND
	} phase_t;

	phase_t phase;
	phase_t next_phase;
	// read_word holds no instruction in the first cycle after reset
	logic word_valid;
	opcode_t held_opcode;
	inst_tail_u held_tail;

	always_comb
	begin
		next_phase = PH_NEW;
		execute = 1'b0;
		read_addr = st.next_pc;
		opcode = opcode_t'(read_word[7:0]);
		tail.word = {8'h00, read_word[15:8]};
		case (phase)
			PH_NEW:
			begin
				if (word_valid)
				begin
					if (opcode_loads_upper(opcode))
					begin
						next_phase = PH_UPPER;
						read_addr = st.pc + 16'd2;
					end
					else
						execute = 1'b1;
				end
			end
			PH_UPPER:
			begin
				// byte 2 arrives in the low half of the word read at pc+2
				opcode = held_opcode;
				tail.word = {read_word[7:0], held_tail.b.d8};
				if (opcode_loads_operand(opcode))
				begin
					next_phase = PH_OPERAND;
					read_addr = tail.word;
				end
				else
					execute = 1'b1;
			end
			default:
			begin
				opcode = held_opcode;
				tail = held_tail;
				execute = 1'b1;
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			phase <= PH_NEW;
			word_valid <= 1'b0;
		end
		else
		begin
			phase <= next_phase;
			word_valid <= 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		held_opcode <= opcode;
		held_tail <= tail;
	end
endmodule

// ==== hw/f8_pkg.sv ====
`include "f8_config.svh"

package f8_pkg;

	typedef enum logic [7:0]
	{
		NOP = 8'h00,
		TRAP = 8'h01,
		ADD_XL_IMMD = 8'h10,
		SUB_XL_IMMD = 8'h11,
		AND_XL_IMMD = 8'h12,
		OR_XL_IMMD = 8'h13,
		XOR_XL_IMMD = 8'h14,
		ADD_XL_DIR = 8'h18,
		SUB_XL_DIR = 8'h19,
		INC_XL = 8'h20,
		DEC_XL = 8'h21,
		CLR_XL = 8'h22,
		LD_XL_IMMD = 8'h30,
		LD_XL_DIR = 8'h31,
		LD_XL_YL = 8'h32,
		LDW_Y_IMMD = 8'h38,
		LD_DIR_XL = 8'h40,
		LDW_DIR_Y = 8'h41,
		JP_IMMD = 8'h50,
		JR_D = 8'h58,
		JRZ_D = 8'h59,
		JRNZ_D = 8'h5a,
		JRC_D = 8'h5b,
		JRNC_D = 8'h5c
	} opcode_t;

	// bit positions in the 8-bit flag word
	typedef enum logic [2:0]
	{
		FLAG_C = 3'd1,
		FLAG_N = 3'd2,
		FLAG_Z = 3'd3
	} flag_idx_t;

	// instruction bytes 1 and 2, byte 1 in the low half
	typedef union packed
	{
		logic [15:0] word;
		struct packed
		{
			logic [7:0] hi;
			logic [7:0] d8;
		} b;
	} inst_tail_u;

	function automatic logic [`F8_ADDR_W-1:0] opcode_size(opcode_t op);
		case (op)
			ADD_XL_IMMD, SUB_XL_IMMD, AND_XL_IMMD, OR_XL_IMMD, XOR_XL_IMMD,
			LD_XL_IMMD, JR_D, JRZ_D, JRNZ_D, JRC_D, JRNC_D:
				return 2;
			ADD_XL_DIR, SUB_XL_DIR, LD_XL_DIR, LDW_Y_IMMD, LD_DIR_XL, LDW_DIR_Y, JP_IMMD:
				return 3;
			default:
				return 1;
		endcase
	endfunction

	function automatic logic opcode_loads_upper(opcode_t op);
		return opcode_size(op) == 3;
	endfunction

	function automatic logic opcode_loads_operand(opcode_t op);
		return op == ADD_XL_DIR || op == SUB_XL_DIR || op == LD_XL_DIR;
	endfunction

endpackage

// ==== hw/f8_registers.sv ====
`timescale 1ns/1ps
`include "f8_config.svh"

module f8_registers
(
	input logic clk,
	input logic reset,
	f8_state_if.regs st
);
	import f8_pkg::*;

	// only C, N and Z exist, the rest of f reads zero
	localparam logic [7:0] FLAG_MASK = (8'h01 << FLAG_C) | (8'h01 << FLAG_N) | (8'h01 << FLAG_Z);

	always_ff @(posedge clk)
	begin
		if (st.reg_wr_en[0])
		begin
			if (st.reg_wr_sel)
				st.y[7:0] <= st.reg_wr_data[7:0];
			else
				st.x[7:0] <= st.reg_wr_data[7:0];
		end
		if (st.reg_wr_en[1])
		begin
			if (st.reg_wr_sel)
				st.y[15:8] <= st.reg_wr_data[15:8];
			else
				st.x[15:8] <= st.reg_wr_data[15:8];
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			st.pc <= `F8_RESET_VECTOR;
			st.f <= '0;
		end
		else
		begin
			st.pc <= st.next_pc;
			st.f <= st.next_f & FLAG_MASK;
		end
	end
endmodule

// ==== hw/f8_state_if.sv ====
`timescale 1ns/1ps

interface f8_state_if;
	logic [15:0] x;
	logic [15:0] y;
	logic [7:0] f;
	logic [15:0] pc;
	logic [15:0] next_pc;
	logic [7:0] next_f;
	// 0 selects x, 1 selects y
	logic reg_wr_sel;
	logic [15:0] reg_wr_data;
	logic [1:0] reg_wr_en;

	modport regs(output x, y, f, pc,
		input next_pc, next_f, reg_wr_sel, reg_wr_data, reg_wr_en);
	modport exec(input x, y, f, pc,
		output next_pc, next_f, reg_wr_sel, reg_wr_data, reg_wr_en);
	modport fetch(input pc, next_pc);
endinterface

// ==== project.f ====
+incdir+hw
hw/f8_pkg.sv
hw/f8_state_if.sv
hw/f8_registers.sv
hw/f8_fetch.sv
hw/f8_execute.sv
hw/f8_bank_split.sv
hw/f8_core.sv
test/f8_core_sva.sv
test/f8_core_tb.sv

// ==== test/f8_core_sva.sv ====
`timescale 1ns/1ps

module f8_core_sva
(
	input logic clk,
	input logic reset,
	input logic mem_write_en_even,
	input logic mem_write_en_odd,
	input logic trap
);
	int unsigned failures = 0;

	// the first reset edge clears the fetch phase, later reset cycles must be quiet
	quiet_in_reset: assert property (@(posedge clk)
		reset && $past(reset) |-> !mem_write_en_even && !mem_write_en_odd && !trap)
	else
	begin
		failures++;
		$error("write enable or trap high while in reset");
	end

	trap_holds: assert property (@(posedge clk) disable iff (reset) trap |=> trap)
	else
	begin
		failures++;
		$error("trap dropped without a reset");
	end

	// core is parked on the trap, nothing may reach memory
	quiet_after_trap: assert property (@(posedge clk) disable iff (reset)
		trap |=> !mem_write_en_even && !mem_write_en_odd)
	else
	begin
		failures++;
		$error("memory write after trap");
	end
endmodule

// ==== test/f8_core_tb.sv ====
`timescale 1ns/1ps
`include "f8_config.svh"

module f8_core_tb;
	import f8_pkg::*;

	localparam int CLK_PERIOD = 10;
	localparam int RESET_CYCLES = 5;
	localparam int PROG_LEN = 60;
	// random part, then a store of xl, a store of y and the trap
	localparam int TOTAL_LEN = PROG_LEN + 3;
	localparam int CYCLE_LIMIT = RESET_CYCLES + 3 * TOTAL_LEN + 100;
	localparam int BANK_SIZE = 1 << `F8_BANK_ADDR_W;
	localparam opcode_t RANDOM_OPS [23] = '{NOP, ADD_XL_IMMD, SUB_XL_IMMD, AND_XL_IMMD,
		OR_XL_IMMD, XOR_XL_IMMD, ADD_XL_DIR, SUB_XL_DIR, INC_XL, DEC_XL, CLR_XL, LD_XL_IMMD,
		LD_XL_DIR, LD_XL_YL, LDW_Y_IMMD, LD_DIR_XL, LDW_DIR_Y, JP_IMMD, JR_D, JRZ_D, JRNZ_D,
		JRC_D, JRNC_D};

	logic clk;
	logic reset;
	logic [`F8_BANK_ADDR_W-1:0] mem_read_addr_even;
	logic [`F8_BANK_ADDR_W-1:0] mem_read_addr_odd;
	logic [7:0] mem_read_data_even;
	logic [7:0] mem_read_data_odd;
	logic [`F8_BANK_ADDR_W-1:0] mem_write_addr_even;
	logic [`F8_BANK_ADDR_W-1:0] mem_write_addr_odd;
	logic [7:0] mem_write_data_even;
	logic [7:0] mem_write_data_odd;
	logic mem_write_en_even;
	logic mem_write_en_odd;
	logic trap;

	logic [7:0] bank_even [0:BANK_SIZE-1];
	logic [7:0] bank_odd [0:BANK_SIZE-1];
	logic [7:0] image [0:65535];
	logic [7:0] model_mem [0:65535];
	// byte address in the upper 16 bits, data in the low byte
	logic [23:0] expected_writes [$];
	opcode_t prog_op [0:TOTAL_LEN-1];
	logic [15:0] prog_arg [0:TOTAL_LEN-1];
	logic [15:0] prog_addr [0:TOTAL_LEN];
	logic reset_seen;
	logic odd_low;

	bind f8_core f8_core_sva f8_core_sva_i(.*);

	f8_core f8_core_i(.*);

	function automatic int instr_length(opcode_t op);
		case (op)
			ADD_XL_IMMD, SUB_XL_IMMD, AND_XL_IMMD, OR_XL_IMMD, XOR_XL_IMMD, LD_XL_IMMD,
			JR_D, JRZ_D, JRNZ_D, JRC_D, JRNC_D:
				return 2;
			ADD_XL_DIR, SUB_XL_DIR, LD_XL_DIR, LDW_Y_IMMD, LD_DIR_XL, LDW_DIR_Y, JP_IMMD:
				return 3;
			default:
				return 1;
		endcase
	endfunction

	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display("Simulation finished: FAIL");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
			fail_run($sformatf("** Error: %s is 0x%0h, expected 0x%0h", name, actual,
				expected));
	endtask

	task automatic build_program();
		int k;
		logic [15:0] target;
		for (int a = 0; a < 65536; a++)
			image[a] = 8'(a) ^ 8'(a >> 8);
		for (int a = 0; a < 256; a++)
			image[a] = 8'($urandom);
		for (int i = 0; i < TOTAL_LEN; i++)
		begin
			if (i == 0)
				prog_op[i] = LD_XL_IMMD;
			else if (i == 1)
				prog_op[i] = LDW_Y_IMMD;
			else if (i == PROG_LEN)
				prog_op[i] = LD_DIR_XL;
			else if (i == PROG_LEN + 1)
				prog_op[i] = LDW_DIR_Y;
			else if (i == PROG_LEN + 2)
				prog_op[i] = TRAP;
			else
				prog_op[i] = RANDOM_OPS[$urandom_range(22)];
			if (prog_op[i] inside {ADD_XL_DIR, SUB_XL_DIR, LD_XL_DIR, LD_DIR_XL, LDW_DIR_Y})
				prog_arg[i] = 16'($urandom_range(254));
			else if ($urandom_range(3) == 0)
				prog_arg[i] = 16'h0000;
			else
				prog_arg[i] = 16'($urandom);
		end
		prog_addr[0] = `F8_RESET_VECTOR;
		for (int i = 0; i < TOTAL_LEN; i++)
			prog_addr[i + 1] = prog_addr[i] + 16'(instr_length(prog_op[i]));
		// forward jumps skip up to three instructions and never pass the first store
		for (int i = 0; i < PROG_LEN; i++)
		begin
			if (prog_op[i] inside {JP_IMMD, JR_D, JRZ_D, JRNZ_D, JRC_D, JRNC_D})
			begin
				k = $urandom_range((PROG_LEN - 1 - i) < 3 ? PROG_LEN - 1 - i : 3);
				target = prog_addr[i + 1 + k];
				prog_arg[i] = prog_op[i] == JP_IMMD ? target : target - prog_addr[i];
			end
		end
		for (int i = 0; i < TOTAL_LEN; i++)
		begin
			image[prog_addr[i]] = prog_op[i];
			if (instr_length(prog_op[i]) > 1)
				image[prog_addr[i] + 16'd1] = prog_arg[i][7:0];
			if (instr_length(prog_op[i]) > 2)
				image[prog_addr[i] + 16'd2] = prog_arg[i][15:8];
		end
		for (int a = 0; a < 65536; a++)
		begin
			if (a[0])
				bank_odd[a >> 1] = image[a];
			else
				bank_even[a >> 1] = image[a];
		end
	endtask

	task automatic model_store(input logic [15:0] addr, input logic [7:0] data);
		model_mem[addr] = data;
		expected_writes.push_back({addr, data});
	endtask

	// only C and Z are tracked as N never leaves the core
	task automatic run_model();
		logic [15:0] pc;
		logic [15:0] next_pc;
		logic [15:0] y;
		logic [15:0] word;
		logic [7:0] xl;
		logic [7:0] b1;
		logic [7:0] v;
		logic [8:0] r;
		logic fc;
		logic fz;
		opcode_t op;
		int steps;
		for (int a = 0; a < 65536; a++)
			model_mem[a] = image[a];
		pc = `F8_RESET_VECTOR;
		xl = 8'h00;
		y = 16'h0000;
		fc = 1'b0;
		fz = 1'b0;
		steps = 0;
		op = opcode_t'(model_mem[pc]);
		while (op != TRAP && steps < 4 * TOTAL_LEN)
		begin
			b1 = model_mem[pc + 16'd1];
			word = {model_mem[pc + 16'd2], b1};
			v = op inside {ADD_XL_DIR, SUB_XL_DIR, LD_XL_DIR} ? model_mem[word] : b1;
			next_pc = pc + 16'(instr_length(op));
			case (op)
				ADD_XL_IMMD, ADD_XL_DIR:
				begin
					r = {1'b0, xl} + {1'b0, v};
					fc = r[8];
					xl = r[7:0];
				end
				SUB_XL_IMMD, SUB_XL_DIR:
				begin
					fc = xl >= v;
					xl = xl - v;
				end
				INC_XL:
				begin
					fc = xl == 8'hff;
					xl = xl + 8'd1;
				end
				DEC_XL:
				begin
					fc = xl != 8'h00;
					xl = xl - 8'd1;
				end
				AND_XL_IMMD:
					xl = xl & v;
				OR_XL_IMMD:
					xl = xl | v;
				XOR_XL_IMMD:
					xl = xl ^ v;
				LD_XL_IMMD, LD_XL_DIR:
					xl = v;
				LD_XL_YL:
					xl = y[7:0];
				CLR_XL:
					xl = 8'h00;
				LDW_Y_IMMD:
				begin
					// word load takes Z from all 16 bits
					y = word;
					fz = word == 16'h0000;
				end
				LD_DIR_XL:
					model_store(word, xl);
				LDW_DIR_Y:
				begin
					model_store(word, y[7:0]);
					model_store(word + 16'd1, y[15:8]);
				end
				JP_IMMD:
					next_pc = word;
				JR_D, JRZ_D, JRNZ_D, JRC_D, JRNC_D:
				begin
					if (op == JR_D || (op == JRZ_D && fz) || (op == JRNZ_D && !fz)
						|| (op == JRC_D && fc) || (op == JRNC_D && !fc))
						next_pc = pc + {{8{b1[7]}}, b1};
				end
				default:
				begin
				end
			endcase
			if (op inside {ADD_XL_IMMD, ADD_XL_DIR, SUB_XL_IMMD, SUB_XL_DIR, INC_XL, DEC_XL,
				AND_XL_IMMD, OR_XL_IMMD, XOR_XL_IMMD, LD_XL_IMMD, LD_XL_DIR, LD_XL_YL})
				fz = xl == 8'h00;
			pc = next_pc;
			op = opcode_t'(model_mem[pc]);
			steps++;
		end
		if (op != TRAP)
			fail_run("reference model never reached the trap");
	endtask

	task automatic check_write(input logic odd, input logic [14:0] bank_addr,
		input logic [7:0] data);
		logic [23:0] entry;
		string bank_name;
		if (odd)
			bank_name = "odd";
		else
			bank_name = "even";
		if (expected_writes.size() == 0)
			fail_run($sformatf("memory write to the %s bank that the model does not expect",
				bank_name));
		else
		begin
			entry = expected_writes.pop_front();
			check("write bank, 1 for odd", odd, entry[8]);
			check({"mem_write_addr_", bank_name}, bank_addr, entry[23:9]);
			check({"mem_write_data_", bank_name}, data, entry[7:0]);
		end
	endtask

	initial
	begin
		clk = 1'b0;
		forever
			#(CLK_PERIOD / 2) clk = ~clk;
	end

	// synchronous banks where a write lands before the read of the same edge
	always @(posedge clk)
	begin
		if (mem_write_en_even)
			bank_even[mem_write_addr_even] = mem_write_data_even;
		if (mem_write_en_odd)
			bank_odd[mem_write_addr_odd] = mem_write_data_odd;
		mem_read_data_even <= bank_even[mem_read_addr_even];
		mem_read_data_odd <= bank_odd[mem_read_addr_odd];
	end

	always @(posedge clk)
	begin
		if (f8_core_i.f8_core_sva_i.failures != 0)
			fail_run("a bound assertion on the core failed");
		if (reset)
		begin
			if (reset_seen)
			begin
				check("mem_write_en_even", mem_write_en_even, 0);
				check("mem_write_en_odd", mem_write_en_odd, 0);
				check("trap", trap, 0);
			end
			reset_seen = 1'b1;
		end
		else
		begin
			// low byte of the access goes first
			odd_low = mem_write_en_even && mem_write_en_odd
				&& ({mem_write_addr_odd, 1'b1} < {mem_write_addr_even, 1'b0});
			if (odd_low)
				check_write(1'b1, mem_write_addr_odd, mem_write_data_odd);
			if (mem_write_en_even)
				check_write(1'b0, mem_write_addr_even, mem_write_data_even);
			if (mem_write_en_odd && !odd_low)
				check_write(1'b1, mem_write_addr_odd, mem_write_data_odd);
		end
	end

	initial
	begin
		#(CYCLE_LIMIT * CLK_PERIOD);
		fail_run("timeout: the core did not reach the trap in time");
	end

	initial
	begin
		reset_seen = 1'b0;
		reset = 1'b1;
		mem_read_data_even = 8'h00;
		mem_read_data_odd = 8'h00;
		void'($urandom(16831));
		build_program();
		run_model();
		repeat (RESET_CYCLES)
			@(posedge clk);
		reset <= 1'b0;
		do
			@(posedge clk);
		while (trap !== 1'b1);
		repeat (10)
		begin
			@(posedge clk);
			check("trap", trap, 1);
		end
		check("stores left in the model", expected_writes.size(), 0);
		for (int a = 0; a < 256; a++)
			check($sformatf("data memory byte 0x%02h", a),
				a[0] ? bank_odd[a >> 1] : bank_even[a >> 1], model_mem[a]);
		if (f8_core_i.f8_core_sva_i.failures == 0)
		begin
			$display("Simulation finished: PASS");
			$finish;
		end
		else
			fail_run("bound assertions reported failures");
	end
endmodule
